// File: build.f
+incdir+hdl
hdl/fb_pkg.sv
hdl/display_timing.sv
hdl/fb_bram.sv
hdl/line_drawer.sv
hdl/fb_scanout.sv
hdl/fb_line_top.sv
verif/tb_clock.sv
verif/fb_line_asserts.sv
verif/tb_fb_line.sv

// File: Makefile
# Verilator build and run of the framebuffer line testbench

TOP = tb_fb_line
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, log in $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
		if grep -q "TEST RESULT: FAIL" $(LOG) || [ $$status -ne 0 ]; then \
			exit 1; \
		fi

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_fb_line.sv
// testbench for fb_line_top, checks every output on every cycle
// model counts rising edges since reset release, outputs lag the counter by 3 edges
// stimulus is only reset, extra pulses placed from a fixed seed
`default_nettype none

`include "fb_cfg.svh"

module tb_fb_line;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int H_BLANK = `FB_H_FP + `FB_H_SYNC + `FB_H_BP;
    localparam int V_BLANK = `FB_V_FP + `FB_V_SYNC + `FB_V_BP;
    localparam int H_TOTAL = `FB_H_ACTIVE + H_BLANK;  // 800
    localparam int V_TOTAL = `FB_V_ACTIVE + V_BLANK;  // 525
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int OUT_LAG    = 3;  // counter reg, RAM stage, output reg
    localparam int RST_CYCLES = 8;
    localparam int N_PULSES   = 3;
    localparam int MAX_PULSE  = 8;
    localparam int CLK_NS     = 4;
    // worst case test length plus one spare frame
    localparam longint WATCHDOG_CYCLES = RST_CYCLES + FRAME_CYCLES + OUT_LAG
        + N_PULSES * (2 * FRAME_CYCLES + MAX_PULSE + OUT_LAG) + FRAME_CYCLES;

    logic                     clk_pix;
    logic                     arst_n;
    logic                     vga_hsync;
    logic                     vga_vsync;
    logic [`FB_COLR_BITS-1:0] vga_r;
    logic [`FB_COLR_BITS-1:0] vga_g;
    logic [`FB_COLR_BITS-1:0] vga_b;

    int     cycle_cnt;  // edges since reset release, 0 while in reset
    integer seed;

    tb_clock tb_clock_inst (
        .clk_pix (clk_pix)
    );

    fb_line_top fb_line_top_inst (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: time %0t signal %s expected %0h actual %0h",
                     $time, name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // expected pins for a given edge count, straight from the timing rules
    task automatic model_outputs(input int m, output logic hs, output logic vs,
                                 output logic [`FB_COLR_BITS-1:0] colr);
        int n;
        int h;
        int v;
        int x;
        int y;
        if (m < OUT_LAG) begin
            hs   = 1'b1;  // still the reset values
            vs   = 1'b1;
            colr = '0;
        end else begin
            n = m - OUT_LAG;
            h = n % H_TOTAL;               // 0 is start of front porch
            v = (n / H_TOTAL) % V_TOTAL;
            x = h - H_BLANK;               // screen coords, active from 0
            y = v - V_BLANK;
            hs = !(h >= `FB_H_FP && h < `FB_H_FP + `FB_H_SYNC);
            vs = !(v >= `FB_V_FP && v < `FB_V_FP + `FB_V_SYNC);
            if (y == `FB_LINE_Y && x >= 0 && x < `FB_WIDTH) begin
                colr = '1;  // the drawn row
            end else begin
                colr = '0;
            end
        end
    endtask

    // check at the falling edge, then set reset for the next rising edge
    task automatic run_cycle(input logic rst_level);
        logic                     hs_exp;
        logic                     vs_exp;
        logic [`FB_COLR_BITS-1:0] colr_exp;
        @(negedge clk_pix);
        if (arst_n) begin
            cycle_cnt = cycle_cnt + 1;
        end else begin
            cycle_cnt = 0;  // model restarts with the DUT
        end
        model_outputs(cycle_cnt, hs_exp, vs_exp, colr_exp);
        check_value("vga_hsync", hs_exp, vga_hsync);
        check_value("vga_vsync", vs_exp, vga_vsync);
        check_value("vga_r", colr_exp, vga_r);
        check_value("vga_g", colr_exp, vga_g);
        check_value("vga_b", colr_exp, vga_b);
        arst_n = rst_level;
    endtask

    task automatic run_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            run_cycle(1'b1);
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("timeout: the test did not finish within its expected run time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int offset;
        int pulse_len;
        arst_n    = 1'b0;
        cycle_cnt = 0;
        seed      = 44;
        @(posedge clk_pix);  // first reset edge
        for (int i = 1; i < RST_CYCLES; i++) begin
            run_cycle(1'b0);
        end
        run_cycle(1'b1);  // release
        run_cycles(FRAME_CYCLES + OUT_LAG);  // one clean frame
        for (int p = 0; p < N_PULSES; p++) begin
            offset    = 1 + ({$random(seed)} % (FRAME_CYCLES - 1));
            pulse_len = 1 + ({$random(seed)} % MAX_PULSE);
            $display("reset pulse %0d, %0d cycles, %0d cycles into the frame",
                     p, pulse_len, offset);
            run_cycles(offset);
            for (int i = 0; i < pulse_len; i++) begin
                run_cycle(1'b0);
            end
            run_cycle(1'b1);
            run_cycles(FRAME_CYCLES + OUT_LAG);  // line must be back
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fb_line_asserts.sv
// concurrent checks on fb_line_top, attached with bind
// vsync pulse length assumes the line length from the cfg header
// needs the drawer instance named line_drawer_inst inside the top
`default_nettype none

`include "fb_cfg.svh"

module fb_line_asserts (
    input wire logic                clk_pix,
    input wire logic                arst_n,
    input wire logic                vga_hsync,
    input wire logic                vga_vsync,
    input wire logic                we,          // drawer write strobe
    input wire fb_pkg::draw_state_t draw_state
);
    timeunit 1ns;
    timeprecision 100ps;

    import fb_pkg::*;

    localparam int LINE_CYCLES = `FB_H_ACTIVE + `FB_H_FP + `FB_H_SYNC + `FB_H_BP;
    localparam int VS_CYCLES   = `FB_V_SYNC * LINE_CYCLES;  // vsync low time

    logic rst_held = 1'b0;  // reset seen at the previous edge
    int   vs_low_cnt;       // consecutive low samples of vga_vsync

    always_ff @(posedge clk_pix) begin
        rst_held <= !arst_n;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vs_low_cnt <= 0;
        end else if (!vga_vsync) begin
            vs_low_cnt <= vs_low_cnt + 1;
        end else begin
            vs_low_cnt <= 0;  // pulse over
        end
    end

    // second cycle of reset onwards, syncs idle high
    sync_idle_in_reset: assert property (
        @(posedge clk_pix) (rst_held && !arst_n) |-> (vga_hsync && vga_vsync)
    ) else $error("syncs not idle while reset is held");

    // vsync pulse must span exactly the sync lines
    vsync_pulse_len: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        $rose(vga_vsync) |-> (vs_low_cnt == VS_CYCLES)
    ) else $error("vga_vsync low for %0d cycles", vs_low_cnt);

    no_write_when_done: assert property (
        @(posedge clk_pix) disable iff (!arst_n)
        (draw_state == DRAW_DONE) |-> !we
    ) else $error("framebuffer write after the line drawer finished");

endmodule

bind fb_line_top fb_line_asserts fb_line_asserts_inst (
    .clk_pix    (clk_pix),
    .arst_n     (arst_n),
    .vga_hsync  (vga_hsync),
    .vga_vsync  (vga_vsync),
    .we         (fb_we),
    .draw_state (line_drawer_inst.state)
);

`default_nettype wire

// File: verif/tb_clock.sv
// free-running pixel clock for the testbench, 4 ns period
// starts low, first rising edge at 2 ns
`default_nettype none

module tb_clock (
    output logic clk_pix
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_NS = 2;  // half of the 4 ns period

    initial begin
        clk_pix = 1'b0;
        forever #(HALF_NS) clk_pix = ~clk_pix;
    end

endmodule

`default_nettype wire

// File: hdl/fb_line_top.sv
// framebuffer line demo top, clk_pix comes straight from outside
// no clock generator, reset is asynchronous and active low
`default_nettype none

`include "fb_cfg.svh"

module fb_line_top (
    input  wire logic                clk_pix,
    input  wire logic                arst_n,
    output logic                     vga_hsync,
    output logic                     vga_vsync,
    output logic [`FB_COLR_BITS-1:0] vga_r,
    output logic [`FB_COLR_BITS-1:0] vga_g,
    output logic [`FB_COLR_BITS-1:0] vga_b
);
    import fb_pkg::*;

    coord_t   sx;          // screen position
    coord_t   sy;
    logic     hsync;
    logic     vsync;
    logic     frame;
    logic     fb_we;       // drawer write side
    fb_addr_t fb_addr_write;
    logic     fb_colr_write;
    fb_addr_t fb_addr_read; // scanout read side
    logic     fb_colr_read;

    display_timing display_timing_inst (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .frame   (frame)
    );

    line_drawer line_drawer_inst (
        .clk_pix    (clk_pix),
        .arst_n     (arst_n),
        .frame      (frame),
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .colr_write (fb_colr_write)
    );

    fb_bram fb_bram_inst (
        .clk_pix    (clk_pix),
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .addr_read  (fb_addr_read),
        .data_in    (fb_colr_write),
        .data_out   (fb_colr_read)
    );

    fb_scanout fb_scanout_inst (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .sx        (sx),
        .sy        (sy),
        .hsync     (hsync),
        .vsync     (vsync),
        .frame     (frame),
        .addr_read (fb_addr_read),
        .colr_read (fb_colr_read),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule

`default_nettype wire

// File: hdl/fb_scanout.sv
// reads the framebuffer in raster order and drives the VGA pins
// framebuffer sits unscaled in the top-left corner, rest is black
// outputs lag the input coordinates and syncs by two cycles
`default_nettype none

`include "fb_cfg.svh"

module fb_scanout (
    input  wire logic                     clk_pix,
    input  wire logic                     arst_n,
    input  wire fb_pkg::coord_t           sx,
    input  wire fb_pkg::coord_t           sy,
    input  wire logic                     hsync,
    input  wire logic                     vsync,
    input  wire logic                     frame,
    output fb_pkg::fb_addr_t              addr_read,
    input  wire logic                     colr_read,  // pixel bit from RAM
    output logic                          vga_hsync,
    output logic                          vga_vsync,
    output logic [`FB_COLR_BITS-1:0]      vga_r,
    output logic [`FB_COLR_BITS-1:0]      vga_g,
    output logic [`FB_COLR_BITS-1:0]      vga_b
);
    import fb_pkg::*;

    localparam coord_t FB_W = coord_t'(`FB_WIDTH);
    localparam coord_t FB_H = coord_t'(`FB_HEIGHT);
    localparam logic [`FB_COLR_BITS-1:0] COLR_FULL = '1;

    logic paint;     // pixel inside framebuffer area
    logic paint_p1;  // aligned with RAM data
    logic hsync_p1;
    logic vsync_p1;
    logic pix_on;

    always_comb begin
        paint = (sy >= 0) && (sy < FB_H) && (sx >= 0) && (sx < FB_W);
    end

    // read address, address 0 needs no lookahead
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            addr_read <= '0;
        end else if (frame) begin
            addr_read <= '0;  // back to origin
        end else if (paint) begin
            addr_read <= addr_read + 1'b1;
        end
    end

    // match the one-cycle RAM read
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            paint_p1 <= 1'b0;
            hsync_p1 <= 1'b1;
            vsync_p1 <= 1'b1;
        end else begin
            paint_p1 <= paint;
            hsync_p1 <= hsync;
            vsync_p1 <= vsync;
        end
    end

    assign pix_on = paint_p1 && colr_read;  // white only inside the area

    // output registers
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= hsync_p1;
            vga_vsync <= vsync_p1;
            vga_r     <= pix_on ? COLR_FULL : '0;
            vga_g     <= pix_on ? COLR_FULL : '0;
            vga_b     <= pix_on ? COLR_FULL : '0;
        end
    end

endmodule

`default_nettype wire

// File: hdl/line_drawer.sv
// draws one full framebuffer row at FB_LINE_Y, once per reset
// starts on the first frame strobe, then idles in DRAW_DONE
`default_nettype none

`include "fb_cfg.svh"

module line_drawer (
    input  wire logic        clk_pix,
    input  wire logic        arst_n,
    input  wire logic        frame,       // frame start strobe
    output logic             we,
    output fb_pkg::fb_addr_t addr_write,
    output logic             colr_write
);
    import fb_pkg::*;

    localparam int     CNTW     = $clog2(`FB_WIDTH);
    localparam fb_addr_t ROW_BASE = fb_addr_t'(`FB_LINE_Y * `FB_WIDTH);  // first pixel
    localparam logic [CNTW-1:0] LAST_COL = CNTW'(`FB_WIDTH - 1);

    draw_state_t     state;
    logic [CNTW-1:0] cnt_draw;  // column being written

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state      <= DRAW_IDLE;
            we         <= 1'b0;
            addr_write <= '0;
            colr_write <= 1'b0;
            cnt_draw   <= '0;
        end else begin
            case (state)
                DRAW_IDLE: begin
                    if (frame) begin
                        we         <= 1'b1;  // first write next cycle
                        colr_write <= 1'b1;  // pixel on
                        addr_write <= ROW_BASE;
                        cnt_draw   <= '0;
                        state      <= DRAW_RUN;
                    end
                end
                DRAW_RUN: begin
                    if (cnt_draw < LAST_COL) begin
                        addr_write <= addr_write + 1'b1;
                        cnt_draw   <= cnt_draw + 1'b1;
                    end else begin
                        we    <= 1'b0;  // row complete
                        state <= DRAW_DONE;
                    end
                end
                DRAW_DONE: begin
                    we <= 1'b0;  // stays here until reset
                end
                default: begin
                    we    <= 1'b0;
                    state <= DRAW_DONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/fb_bram.sv
// one-bit simple dual-port RAM, single clock, read data one cycle late
// no reset on the array; contents start at zero in simulation only
`default_nettype none

`include "fb_cfg.svh"

module fb_bram (
    input  wire logic             clk_pix,
    input  wire logic             we,
    input  wire fb_pkg::fb_addr_t addr_write,
    input  wire fb_pkg::fb_addr_t addr_read,
    input  wire logic             data_in,
    output logic                  data_out
);
    localparam int DEPTH = `FB_WIDTH * `FB_HEIGHT;

    logic mem [0:DEPTH-1];  // one word per pixel

    // sim start state, blank framebuffer
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 1'b0;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
        data_out <= mem[addr_read];  // registered read port
    end

endmodule

`default_nettype wire

// File: hdl/display_timing.sv
// 640x480 timing, counters start in front porch and end at last active pixel
// all outputs registered, one cycle behind the counters
// syncs active low
`default_nettype none

`include "fb_cfg.svh"

module display_timing (
    input  wire logic      clk_pix,
    input  wire logic      arst_n,
    output fb_pkg::coord_t sx,      // horizontal position
    output fb_pkg::coord_t sy,      // vertical position
    output logic           hsync,
    output logic           vsync,
    output logic           frame    // one cycle at frame origin
);
    import fb_pkg::*;

    // horizontal: front porch, sync, back porch, then active from 0
    localparam coord_t H_STA  = coord_t'(-(`FB_H_FP + `FB_H_SYNC + `FB_H_BP));
    localparam coord_t HS_STA = coord_t'(H_STA + `FB_H_FP);   // sync start
    localparam coord_t HS_END = coord_t'(HS_STA + `FB_H_SYNC - 1);
    localparam coord_t H_END  = coord_t'(`FB_H_ACTIVE - 1);

    // vertical, same order
    localparam coord_t V_STA  = coord_t'(-(`FB_V_FP + `FB_V_SYNC + `FB_V_BP));
    localparam coord_t VS_STA = coord_t'(V_STA + `FB_V_FP);
    localparam coord_t VS_END = coord_t'(VS_STA + `FB_V_SYNC - 1);
    localparam coord_t V_END  = coord_t'(`FB_V_ACTIVE - 1);

    coord_t h_cnt;  // raw counters
    coord_t v_cnt;

    // counters, vertical steps on horizontal wrap
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= H_STA;
            v_cnt <= V_STA;
        end else begin
            if (h_cnt == H_END) begin
                h_cnt <= H_STA;
                if (v_cnt == V_END) begin
                    v_cnt <= V_STA;  // next frame
                end else begin
                    v_cnt <= v_cnt + coord_t'(1);
                end
            end else begin
                h_cnt <= h_cnt + coord_t'(1);
            end
        end
    end

    // decode and register
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx    <= H_STA;
            sy    <= V_STA;
            hsync <= 1'b1;  // inactive
            vsync <= 1'b1;
            frame <= 1'b0;
        end else begin
            sx    <= h_cnt;
            sy    <= v_cnt;
            hsync <= ~(h_cnt >= HS_STA && h_cnt <= HS_END);
            vsync <= ~(v_cnt >= VS_STA && v_cnt <= VS_END);
            frame <= (h_cnt == H_STA) && (v_cnt == V_STA);  // deep in vblank
        end
    end

endmodule

`default_nettype wire

// File: hdl/fb_pkg.sv
// shared types for the framebuffer line demo
// address width follows the framebuffer size in the cfg header
`default_nettype none

`include "fb_cfg.svh"

package fb_pkg;

    // signed screen coordinate, negative during blanking
    typedef logic signed [`FB_CORDW-1:0] coord_t;

    // linear framebuffer address, row major
    typedef logic [$clog2(`FB_WIDTH * `FB_HEIGHT)-1:0] fb_addr_t;

    // line drawer states
    typedef enum logic [1:0] {
        DRAW_IDLE,   // waiting for frame start
        DRAW_RUN,    // writing the row
        DRAW_DONE    // parked until reset
    } draw_state_t;

endpackage

`default_nettype wire

// File: hdl/fb_cfg.svh
// display timing and framebuffer settings for 640x480 at the pixel clock
// the line row must stay inside the framebuffer height
// all sizes in pixels or lines
`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// screen coordinate width, signed
`define FB_CORDW 16

// horizontal timing in pixels
`define FB_H_ACTIVE 640
`define FB_H_FP     16   // front porch
`define FB_H_SYNC   96
`define FB_H_BP     48   // back porch

// vertical timing in lines
`define FB_V_ACTIVE 480
`define FB_V_FP     10
`define FB_V_SYNC   2
`define FB_V_BP     33

// framebuffer, one bit per pixel
`define FB_WIDTH  160
`define FB_HEIGHT 120
`define FB_LINE_Y 60     // half of FB_HEIGHT

`define FB_COLR_BITS 4   // per VGA channel

`endif
